// ==== logic/cpu_ex.sv ====
`timescale 1ns/10ps

module cpu_ex(
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  cpu_isa_pkg::Oper_t     op_i,
	input  cpu_isa_pkg::Word_t     a_i,
	input  cpu_isa_pkg::Word_t     b_i,
	input  cpu_pipe_pkg::MemOp_t   memop_i,
	input  cpu_isa_pkg::Word_t     store_i,
	input  logic                   we_i,
	input  cpu_isa_pkg::RegAddr_t  waddr_i,
	input  cpu_isa_pkg::InstAddr_t pc_i,
	output logic                   fwd_we_o,
	output cpu_isa_pkg::RegAddr_t  fwd_waddr_o,
	output cpu_isa_pkg::Word_t     fwd_result_o,
	output logic                   fwd_is_load_o,
	output cpu_isa_pkg::Word_t     mem_result_o,
	output cpu_pipe_pkg::MemOp_t   mem_memop_o,
	output cpu_isa_pkg::Word_t     mem_store_o,
	output logic                   mem_we_o,
	output cpu_isa_pkg::RegAddr_t  mem_waddr_o,
	output cpu_isa_pkg::InstAddr_t mem_pc_o
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	Word_t result;

	always_comb begin
		case (op_i)
			ADD:     result = a_i + b_i;
			SUB:     result = a_i - b_i;
			AND:     result = a_i & b_i;
			OR:      result = a_i | b_i;
			XOR:     result = a_i ^ b_i;
			SLT:     result = {31'b0, $signed(a_i) < $signed(b_i)};
			// Shift amount arrives in a
			SLL:     result = b_i << a_i[4:0];
			SRL:     result = b_i >> a_i[4:0];
			LUI:     result = {b_i[15:0], 16'b0};
			default: result = '0;
		endcase
	end

	assign fwd_we_o      = we_i;
	assign fwd_waddr_o   = waddr_i;
	assign fwd_result_o  = result;
	assign fwd_is_load_o = (memop_i == LOAD);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mem_result_o <= '0;
			mem_memop_o  <= NONE;
			mem_store_o  <= '0;
			mem_we_o     <= 1'b0;
			mem_waddr_o  <= '0;
			mem_pc_o     <= RESET_PC;
		end else begin
			mem_result_o <= result;
			mem_memop_o  <= memop_i;
			mem_store_o  <= store_i;
			mem_we_o     <= we_i;
			mem_waddr_o  <= waddr_i;
			mem_pc_o     <= pc_i;
		end
	end

endmodule

// ==== logic/cpu_id.sv ====
`timescale 1ns/10ps

module cpu_id(
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  cpu_isa_pkg::InstAddr_t pc_i,
	input  cpu_isa_pkg::Inst_t     inst_i,
	input  cpu_isa_pkg::Word_t     rdata1_i,
	input  cpu_isa_pkg::Word_t     rdata2_i,
	input  logic                   ex_we_i,
	input  cpu_isa_pkg::RegAddr_t  ex_waddr_i,
	input  cpu_isa_pkg::Word_t     ex_result_i,
	input  logic                   ex_is_load_i,
	input  logic                   mem_we_i,
	input  cpu_isa_pkg::RegAddr_t  mem_waddr_i,
	input  cpu_isa_pkg::Word_t     mem_wdata_i,
	output cpu_isa_pkg::RegAddr_t  raddr1_o,
	output cpu_isa_pkg::RegAddr_t  raddr2_o,
	output logic                   stall_o,
	output logic                   branch_taken_o,
	output cpu_isa_pkg::InstAddr_t branch_target_o,
	output cpu_isa_pkg::Oper_t     ex_op_o,
	output cpu_isa_pkg::Word_t     ex_a_o,
	output cpu_isa_pkg::Word_t     ex_b_o,
	output cpu_pipe_pkg::MemOp_t   ex_memop_o,
	output cpu_isa_pkg::Word_t     ex_store_o,
	output logic                   ex_we_o,
	output cpu_isa_pkg::RegAddr_t  ex_waddr_o,
	output cpu_isa_pkg::InstAddr_t ex_pc_o
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	Opcode_t  opcode;
	Funct_t   funct;
	RegAddr_t rs, rt, rd;
	Word_t    sext_imm, zext_imm;
	Word_t    rs_val, rt_val;

	Oper_t    op;
	Word_t    a, b;
	MemOp_t   memop;
	logic     we;
	RegAddr_t dest;
	logic     uses_rs, uses_rt;

	assign opcode   = inst_i[31:26];
	assign rs       = inst_i[25:21];
	assign rt       = inst_i[20:16];
	assign rd       = inst_i[15:11];
	assign funct    = inst_i[5:0];
	assign sext_imm = {{16{inst_i[15]}}, inst_i[15:0]};
	assign zext_imm = {16'b0, inst_i[15:0]};

	assign raddr1_o = rs;
	assign raddr2_o = rt;

	// Pick the newest of execute, memory and register file
	function automatic Word_t fwd(input RegAddr_t addr, input Word_t reg_val);
		if (addr != '0 && ex_we_i && ex_waddr_i == addr) begin
			return ex_result_i;
		end else if (addr != '0 && mem_we_i && mem_waddr_i == addr) begin
			return mem_wdata_i;
		end
		return reg_val;
	endfunction

	assign rs_val = fwd(rs, rdata1_i);
	assign rt_val = fwd(rt, rdata2_i);

	always_comb begin
		op      = ADD;
		a       = rs_val;
		b       = rt_val;
		memop   = NONE;
		we      = 1'b0;
		dest    = rt;
		uses_rs = 1'b1;
		uses_rt = 1'b0;
		case (opcode)
			OP_SPECIAL: begin
				dest    = rd;
				we      = 1'b1;
				uses_rt = 1'b1;
				case (funct)
					FN_ADDU: op = ADD;
					FN_SUBU: op = SUB;
					FN_AND:  op = AND;
					FN_OR:   op = OR;
					FN_XOR:  op = XOR;
					FN_SLT:  op = SLT;
					FN_SLL, FN_SRL: begin
						op      = (funct == FN_SLL) ? SLL : SRL;
						a       = {27'b0, inst_i[10:6]};
						uses_rs = 1'b0;
					end
					default: begin
						we      = 1'b0;
						uses_rs = 1'b0;
						uses_rt = 1'b0;
					end
				endcase
			end
			OP_ADDIU: begin
				op = ADD;
				b  = sext_imm;
				we = 1'b1;
			end
			OP_SLTI: begin
				op = SLT;
				b  = sext_imm;
				we = 1'b1;
			end
			OP_ANDI: begin
				op = AND;
				b  = zext_imm;
				we = 1'b1;
			end
			OP_ORI: begin
				op = OR;
				b  = zext_imm;
				we = 1'b1;
			end
			OP_XORI: begin
				op = XOR;
				b  = zext_imm;
				we = 1'b1;
			end
			OP_LUI: begin
				op      = LUI;
				b       = zext_imm;
				we      = 1'b1;
				uses_rs = 1'b0;
			end
			OP_LW: begin
				b     = sext_imm;
				memop = LOAD;
				we    = 1'b1;
			end
			OP_SW: begin
				b       = sext_imm;
				memop   = STORE;
				uses_rt = 1'b1;
			end
			OP_BEQ, OP_BNE: uses_rt = 1'b1;
			// Unknown opcode becomes a bubble
			default: uses_rs = 1'b0;
		endcase
	end

	// Load result not ready until memory stage
	assign stall_o = ex_is_load_i && ex_we_i && ex_waddr_i != '0 &&
		((uses_rs && rs == ex_waddr_i) || (uses_rt && rt == ex_waddr_i));

	assign branch_target_o = pc_i + 32'd4 + {sext_imm[29:0], 2'b00};
	assign branch_taken_o  = !stall_o &&
		((opcode == OP_BEQ && rs_val == rt_val) ||
		 (opcode == OP_BNE && rs_val != rt_val));

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_op_o    <= ADD;
			ex_a_o     <= '0;
			ex_b_o     <= '0;
			ex_memop_o <= NONE;
			ex_store_o <= '0;
			ex_we_o    <= 1'b0;
			ex_waddr_o <= '0;
			ex_pc_o    <= RESET_PC;
		end else begin
			ex_op_o    <= op;
			ex_a_o     <= a;
			ex_b_o     <= b;
			ex_store_o <= rt_val;
			ex_waddr_o <= dest;
			ex_pc_o    <= pc_i;
			// Bubble on stall
			ex_memop_o <= stall_o ? NONE : memop;
			ex_we_o    <= we && dest != '0 && !stall_o;
		end
	end

endmodule

// ==== logic/cpu_if.sv ====
`timescale 1ns/10ps

module cpu_if(
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   stall_i,
	input  logic                   branch_taken_i,
	input  cpu_isa_pkg::InstAddr_t branch_target_i,
	input  cpu_isa_pkg::Inst_t     inst_rdata_i,
	output cpu_isa_pkg::InstAddr_t inst_addr_o,
	output cpu_isa_pkg::InstAddr_t id_pc_o,
	output cpu_isa_pkg::Inst_t     id_inst_o
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	InstAddr_t pc;
	InstAddr_t next_pc;

	// Branch in decode redirects after the delay slot fetch
	assign next_pc = branch_taken_i ? branch_target_i : pc + 32'd4;
	assign inst_addr_o = pc;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc        <= RESET_PC;
			id_pc_o   <= RESET_PC;
			id_inst_o <= '0;
		end else if (!stall_i) begin
			pc        <= next_pc;
			id_pc_o   <= pc;
			id_inst_o <= inst_rdata_i;
		end
	end

endmodule

// ==== logic/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	// Basic words
	typedef logic [31:0] Word_t;
	typedef logic [31:0] InstAddr_t;
	typedef logic [31:0] Inst_t;

	// Instruction fields
	typedef logic [4:0] RegAddr_t;
	typedef logic [5:0] Opcode_t;
	typedef logic [5:0] Funct_t;

	// Primary opcodes
	localparam Opcode_t OP_SPECIAL = 6'h00;
	localparam Opcode_t OP_BEQ     = 6'h04;
	localparam Opcode_t OP_BNE     = 6'h05;
	localparam Opcode_t OP_ADDIU   = 6'h09;
	localparam Opcode_t OP_SLTI    = 6'h0a;
	localparam Opcode_t OP_ANDI    = 6'h0c;
	localparam Opcode_t OP_ORI     = 6'h0d;
	localparam Opcode_t OP_XORI    = 6'h0e;
	localparam Opcode_t OP_LUI     = 6'h0f;
	localparam Opcode_t OP_LW      = 6'h23;
	localparam Opcode_t OP_SW      = 6'h2b;

	// SPECIAL function codes
	localparam Funct_t FN_SLL  = 6'h00;
	localparam Funct_t FN_SRL  = 6'h02;
	localparam Funct_t FN_ADDU = 6'h21;
	localparam Funct_t FN_SUBU = 6'h23;
	localparam Funct_t FN_AND  = 6'h24;
	localparam Funct_t FN_OR   = 6'h25;
	localparam Funct_t FN_XOR  = 6'h26;
	localparam Funct_t FN_SLT  = 6'h2a;

	// ALU operations where LUI places b in the upper half
	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLT,
		SLL,
		SRL,
		LUI
	} Oper_t;

endpackage

// ==== logic/cpu_mem.sv ====
`timescale 1ns/10ps

module cpu_mem(
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  cpu_isa_pkg::Word_t     result_i,
	input  cpu_pipe_pkg::MemOp_t   memop_i,
	input  cpu_isa_pkg::Word_t     store_i,
	input  logic                   we_i,
	input  cpu_isa_pkg::RegAddr_t  waddr_i,
	input  cpu_isa_pkg::InstAddr_t pc_i,
	input  cpu_isa_pkg::Word_t     data_rdata_i,
	output cpu_isa_pkg::Word_t     data_addr_o,
	output cpu_isa_pkg::Word_t     data_wdata_o,
	output logic                   data_we_o,
	output logic                   fwd_we_o,
	output cpu_isa_pkg::RegAddr_t  fwd_waddr_o,
	output cpu_isa_pkg::Word_t     fwd_wdata_o,
	output logic                   wb_we_o,
	output cpu_isa_pkg::RegAddr_t  wb_waddr_o,
	output cpu_isa_pkg::Word_t     wb_wdata_o,
	output cpu_isa_pkg::InstAddr_t wb_pc_o
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	Word_t wdata;

	// ALU result is the address for loads and stores
	assign data_addr_o  = result_i;
	assign data_wdata_o = store_i;
	assign data_we_o    = (memop_i == STORE);

	assign wdata       = (memop_i == LOAD) ? data_rdata_i : result_i;
	assign fwd_we_o    = we_i;
	assign fwd_waddr_o = waddr_i;
	assign fwd_wdata_o = wdata;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_we_o    <= 1'b0;
			wb_waddr_o <= '0;
			wb_wdata_o <= '0;
			wb_pc_o    <= RESET_PC;
		end else begin
			wb_we_o    <= we_i && waddr_i != '0;
			wb_waddr_o <= waddr_i;
			wb_wdata_o <= wdata;
			wb_pc_o    <= pc_i;
		end
	end

endmodule

// ==== logic/cpu_pipe_pkg.sv ====
package cpu_pipe_pkg;

	// First fetch address
	localparam cpu_isa_pkg::InstAddr_t RESET_PC = 32'h0000_0000;

	// General register file size
	localparam int REG_COUNT = 32;

	// Data access carried from decode to the memory stage
	typedef enum logic [1:0] {
		NONE,
		LOAD,
		STORE
	} MemOp_t;

endpackage

// ==== logic/regs.sv ====
`timescale 1ns/10ps

module regs(
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  we_i,
	input  cpu_isa_pkg::RegAddr_t waddr_i,
	input  cpu_isa_pkg::Word_t    wdata_i,
	input  cpu_isa_pkg::RegAddr_t raddr1_i,
	input  cpu_isa_pkg::RegAddr_t raddr2_i,
	output cpu_isa_pkg::Word_t    rdata1_o,
	output cpu_isa_pkg::Word_t    rdata2_o
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	Word_t regs_q [REG_COUNT];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	// Write-first bypass with r0 hardwired to zero
	assign rdata1_o = (raddr1_i == '0) ? '0 :
		(we_i && waddr_i == raddr1_i) ? wdata_i : regs_q[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 :
		(we_i && waddr_i == raddr2_i) ? wdata_i : regs_q[raddr2_i];

endmodule

// ==== logic/trivial_mips.sv ====
`timescale 1ns/10ps

module trivial_mips(
	input  logic                   clk,
	input  logic                   rst_n_i,
	output cpu_isa_pkg::InstAddr_t inst_addr_o,
	input  cpu_isa_pkg::Inst_t     inst_rdata_i,
	output cpu_isa_pkg::Word_t     data_addr_o,
	output cpu_isa_pkg::Word_t     data_wdata_o,
	output logic                   data_we_o,
	input  cpu_isa_pkg::Word_t     data_rdata_i,
	output logic                   wb_we_o,
	output cpu_isa_pkg::InstAddr_t wb_pc_o,
	output cpu_isa_pkg::RegAddr_t  wb_waddr_o,
	output cpu_isa_pkg::Word_t     wb_wdata_o
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	// Fetch to decode
	InstAddr_t if_pc;
	Inst_t     if_inst;
	logic      stall;
	logic      branch_taken;
	InstAddr_t branch_target;

	// Register file reads
	RegAddr_t reg_raddr1, reg_raddr2;
	Word_t    reg_rdata1, reg_rdata2;

	// Decode to execute
	Oper_t     idex_op;
	Word_t     idex_a, idex_b, idex_store;
	MemOp_t    idex_memop;
	logic      idex_we;
	RegAddr_t  idex_waddr;
	InstAddr_t idex_pc;

	// Execute to memory
	Word_t     exmem_result, exmem_store;
	MemOp_t    exmem_memop;
	logic      exmem_we;
	RegAddr_t  exmem_waddr;
	InstAddr_t exmem_pc;

	// Forwarding back to decode
	logic     ex_fwd_we, ex_fwd_is_load, mem_fwd_we;
	RegAddr_t ex_fwd_waddr, mem_fwd_waddr;
	Word_t    ex_fwd_result, mem_fwd_wdata;

	cpu_if stage_if(
		.clk, .rst_n_i,
		.stall_i(stall), .branch_taken_i(branch_taken),
		.branch_target_i(branch_target), .inst_rdata_i,
		.inst_addr_o, .id_pc_o(if_pc), .id_inst_o(if_inst)
	);

	cpu_id stage_id(
		.clk, .rst_n_i,
		.pc_i(if_pc), .inst_i(if_inst),
		.rdata1_i(reg_rdata1), .rdata2_i(reg_rdata2),
		.ex_we_i(ex_fwd_we), .ex_waddr_i(ex_fwd_waddr),
		.ex_result_i(ex_fwd_result), .ex_is_load_i(ex_fwd_is_load),
		.mem_we_i(mem_fwd_we), .mem_waddr_i(mem_fwd_waddr), .mem_wdata_i(mem_fwd_wdata),
		.raddr1_o(reg_raddr1), .raddr2_o(reg_raddr2),
		.stall_o(stall), .branch_taken_o(branch_taken), .branch_target_o(branch_target),
		.ex_op_o(idex_op), .ex_a_o(idex_a), .ex_b_o(idex_b),
		.ex_memop_o(idex_memop), .ex_store_o(idex_store),
		.ex_we_o(idex_we), .ex_waddr_o(idex_waddr), .ex_pc_o(idex_pc)
	);

	cpu_ex stage_ex(
		.clk, .rst_n_i,
		.op_i(idex_op), .a_i(idex_a), .b_i(idex_b),
		.memop_i(idex_memop), .store_i(idex_store),
		.we_i(idex_we), .waddr_i(idex_waddr), .pc_i(idex_pc),
		.fwd_we_o(ex_fwd_we), .fwd_waddr_o(ex_fwd_waddr),
		.fwd_result_o(ex_fwd_result), .fwd_is_load_o(ex_fwd_is_load),
		.mem_result_o(exmem_result), .mem_memop_o(exmem_memop),
		.mem_store_o(exmem_store), .mem_we_o(exmem_we),
		.mem_waddr_o(exmem_waddr), .mem_pc_o(exmem_pc)
	);

	cpu_mem stage_mem(
		.clk, .rst_n_i,
		.result_i(exmem_result), .memop_i(exmem_memop), .store_i(exmem_store),
		.we_i(exmem_we), .waddr_i(exmem_waddr), .pc_i(exmem_pc),
		.data_rdata_i, .data_addr_o, .data_wdata_o, .data_we_o,
		.fwd_we_o(mem_fwd_we), .fwd_waddr_o(mem_fwd_waddr), .fwd_wdata_o(mem_fwd_wdata),
		.wb_we_o, .wb_waddr_o, .wb_wdata_o, .wb_pc_o
	);

	// Commit port doubles as the register write
	regs general_regs(
		.clk, .rst_n_i,
		.we_i(wb_we_o), .waddr_i(wb_waddr_o), .wdata_i(wb_wdata_o),
		.raddr1_i(reg_raddr1), .raddr2_i(reg_raddr2),
		.rdata1_o(reg_rdata1), .rdata2_o(reg_rdata2)
	);

endmodule

// ==== run.sh ====
#!/bin/bash
# Build and run the trivial_mips testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_trivial_mips \
	-o sim_trivial_mips > build.log 2>&1 \
	&& ./obj_dir/sim_trivial_mips > sim.log 2>&1 \
	|| { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^NO ERRORS$" sim.log && exit 0 || exit 1

// ==== verification/cpu_asserts.sv ====
`timescale 1ns/10ps

module cpu_asserts(
	input logic                  clk,
	input logic                  rst_n_i,
	input logic                  data_we_o,
	input logic                  wb_we_o,
	input cpu_isa_pkg::RegAddr_t wb_waddr_o,
	input cpu_isa_pkg::Word_t    data_addr_o,
	input cpu_pipe_pkg::MemOp_t  memop_i
);
	import cpu_pipe_pkg::*;

	no_store_in_reset: assert property (@(posedge clk) !rst_n_i |-> !data_we_o)
		else $error("data_we_o high during reset");

	// r0 never written
	commit_nonzero_dest: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_we_o |-> wb_waddr_o != '0)
		else $error("wb_we_o high for register 0");

	aligned_access: assert property (@(posedge clk) disable iff (!rst_n_i)
		memop_i != NONE |-> data_addr_o[1:0] == 2'b00)
		else $error("misaligned data address %h", data_addr_o);

endmodule

// ==== verification/mips_checker.sv ====
`timescale 1ns/10ps

module mips_checker #(
	parameter int END_IDX = 198
)(
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   done_i,
	input  cpu_isa_pkg::Inst_t     prog_i [256],
	input  cpu_isa_pkg::Word_t     data_init_i [64],
	input  cpu_isa_pkg::InstAddr_t inst_addr_i,
	input  cpu_isa_pkg::Word_t     data_addr_i,
	input  cpu_isa_pkg::Word_t     data_wdata_i,
	input  logic                   data_we_i,
	input  logic                   wb_we_i,
	input  cpu_isa_pkg::InstAddr_t wb_pc_i,
	input  cpu_isa_pkg::RegAddr_t  wb_waddr_i,
	input  cpu_isa_pkg::Word_t     wb_wdata_i,
	output int                     errors_o
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	Word_t     gpr [32];
	Word_t     mdata [64];
	InstAddr_t mpc, mnpc;
	logic      mdone;
	logic      after_reset;
	RegAddr_t  last1, last2;
	int        commits, model_writes;
	int        err [1:5];

	// Expected register writes and stores in program order
	Word_t     wq_data [$];
	RegAddr_t  wq_dest [$];
	InstAddr_t wq_pc [$];
	bit        wq_haz [$];
	Word_t     sq_addr [$];
	Word_t     sq_data [$];

	task automatic step_model;
		Inst_t     in;
		Word_t     a, b, res, sx, zx, ea;
		RegAddr_t  rs, rt, dest;
		logic      wr;
		bit        haz;
		bit        rs_src, rt_src;
		InstAddr_t nn;
		in   = prog_i[mpc[9:2]];
		rs   = in[25:21];
		rt   = in[20:16];
		a    = gpr[rs];
		b    = gpr[rt];
		sx   = {{16{in[15]}}, in[15:0]};
		zx   = {16'b0, in[15:0]};
		ea   = a + sx;
		wr   = 1'b1;
		dest = rt;
		res  = '0;
		nn   = mnpc + 32'd4;
		case (in[31:26])
			OP_SPECIAL: begin
				dest = in[15:11];
				case (in[5:0])
					FN_ADDU: res = a + b;
					FN_SUBU: res = a - b;
					FN_AND:  res = a & b;
					FN_OR:   res = a | b;
					FN_XOR:  res = a ^ b;
					FN_SLT:  res = {31'b0, $signed(a) < $signed(b)};
					FN_SLL:  res = b << in[10:6];
					FN_SRL:  res = b >> in[10:6];
					default: wr = 1'b0;
				endcase
			end
			OP_ADDIU: res = a + sx;
			OP_SLTI:  res = {31'b0, $signed(a) < $signed(sx)};
			OP_ANDI:  res = a & zx;
			OP_ORI:   res = a | zx;
			OP_XORI:  res = a ^ zx;
			OP_LUI:   res = {in[15:0], 16'b0};
			OP_LW:    res = mdata[ea[7:2]];
			OP_SW: begin
				wr = 1'b0;
				sq_addr.push_back(ea);
				sq_data.push_back(b);
				mdata[ea[7:2]] = b;
			end
			OP_BEQ, OP_BNE: begin
				wr = 1'b0;
				if ((in[31:26] == OP_BEQ) == (a == b)) begin
					nn = mpc + 32'd4 + {sx[29:0], 2'b00};
				end
			end
			default: wr = 1'b0;
		endcase
		// Only fields that the instruction really reads count as sources
		rs_src = (in[31:26] != OP_LUI);
		rt_src = (in[31:26] == OP_SPECIAL || in[31:26] == OP_SW ||
			in[31:26] == OP_BEQ || in[31:26] == OP_BNE);
		// Reads a result of one of the two instructions just before
		haz = (rs_src && rs != '0 && (rs == last1 || rs == last2)) ||
			(rt_src && rt != '0 && (rt == last1 || rt == last2));
		if (wr && dest != '0) begin
			gpr[dest] = res;
			wq_data.push_back(res);
			wq_dest.push_back(dest);
			wq_pc.push_back(mpc);
			wq_haz.push_back(haz);
			model_writes++;
		end
		last2 = last1;
		last1 = wr ? dest : '0;
		mpc   = mnpc;
		mnpc  = nn;
		mdone = (mpc == END_IDX * 4);
	endtask

	task automatic check_reset_outputs(input string phase);
		if (data_we_i) begin
			err[5]++;
			$display("ERR %0t data_we_o got %b expected 0 %s reset",
				$time, data_we_i, phase);
		end
		if (wb_we_i) begin
			err[5]++;
			$display("ERR %0t wb_we_o got %b expected 0 %s reset",
				$time, wb_we_i, phase);
		end
		if (inst_addr_i != RESET_PC) begin
			err[5]++;
			$display("ERR %0t inst_addr_o got %h expected %h %s reset",
				$time, inst_addr_i, RESET_PC, phase);
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				gpr[i] = '0;
			end
			for (int i = 0; i < 64; i++) begin
				mdata[i] = data_init_i[i];
			end
			mpc = RESET_PC;
			mnpc = RESET_PC + 32'd4;
			mdone = 1'b0;
			last1 = '0;
			last2 = '0;
			after_reset = 1'b1;
			check_reset_outputs("during");
		end else begin
			if (after_reset) begin
				after_reset = 1'b0;
				check_reset_outputs("after");
				$display("test 5 reset values: %0d errors", err[5]);
			end
			if (wb_we_i) begin
				commits++;
				while (wq_data.size() == 0 && !mdone) step_model();
				if (wq_data.size() == 0) begin
					err[4]++;
					$display("Commit at pc %h has no matching instruction in the model",
						wb_pc_i);
				end else begin
					if (wb_pc_i != wq_pc[0]) begin
						err[4]++;
						$display("ERR %0t wb_pc_o got %h expected %h", $time, wb_pc_i, wq_pc[0]);
					end
					if (wb_waddr_i != wq_dest[0] || wb_wdata_i != wq_data[0]) begin
						err[wq_haz[0] ? 2 : 1]++;
						$display("ERR %0t wb_waddr_o/wb_wdata_o got %0d/%h expected %0d/%h",
							$time, wb_waddr_i, wb_wdata_i, wq_dest[0], wq_data[0]);
					end
					void'(wq_data.pop_front());
					void'(wq_dest.pop_front());
					void'(wq_pc.pop_front());
					void'(wq_haz.pop_front());
				end
			end
			if (data_we_i) begin
				while (sq_addr.size() == 0 && !mdone) step_model();
				if (sq_addr.size() == 0) begin
					err[3]++;
					$display("Store to %h that the model never makes", data_addr_i);
				end else begin
					if (data_addr_i[31:2] != sq_addr[0][31:2] || data_wdata_i != sq_data[0]) begin
						err[3]++;
						$display("ERR %0t data_addr_o/data_wdata_o got %h/%h expected %h/%h",
							$time, data_addr_i, data_wdata_i, sq_addr[0], sq_data[0]);
					end
					void'(sq_addr.pop_front());
					void'(sq_data.pop_front());
				end
			end
		end
	end

	always @(posedge done_i) begin
		while (!mdone) step_model();
		$display("test 1 ALU results: %0d errors", err[1]);
		if (commits != model_writes) begin
			err[2]++;
			$display("The DUT made %0d register writes but the model made %0d",
				commits, model_writes);
		end
		$display("test 2 forwarding and load-use: %0d errors", err[2]);
		if (sq_addr.size() != 0) begin
			err[3]++;
			$display("%0d stores of the model never appeared on the data bus", sq_addr.size());
		end
		$display("test 3 stores: %0d errors", err[3]);
		$display("test 4 branches and delay slots: %0d errors", err[4]);
		errors_o = err[1] + err[2] + err[3] + err[4] + err[5];
	end

	initial begin
		commits = 0;
		model_writes = 0;
		errors_o = 0;
		after_reset = 1'b0;
		for (int i = 1; i <= 5; i++) begin
			err[i] = 0;
		end
	end

endmodule

// ==== verification/tb_trivial_mips.sv ====
`timescale 1ns/10ps

module tb_trivial_mips;
	import cpu_isa_pkg::*;

	localparam int PROG_LEN        = 200;
	localparam int END_IDX         = PROG_LEN - 2;
	localparam int RESET_CYCLES    = 8;
	localparam int WATCHDOG_CYCLES = PROG_LEN * 4 + 100;

	logic      clk;
	logic      rst_n;
	logic      done;
	logic [31:0] lcg_state;
	int        errors;

	Inst_t     imem [256];
	Word_t     dmem [64];

	InstAddr_t inst_addr, wb_pc;
	Inst_t     inst_rdata;
	Word_t     data_addr, data_wdata, data_rdata, wb_wdata;
	logic      data_we, wb_we;
	RegAddr_t  wb_waddr;

	bind cpu_mem cpu_asserts bus_asserts(.*);

	trivial_mips uut(
		.clk, .rst_n_i(rst_n),
		.inst_addr_o(inst_addr), .inst_rdata_i(inst_rdata),
		.data_addr_o(data_addr), .data_wdata_o(data_wdata),
		.data_we_o(data_we), .data_rdata_i(data_rdata),
		.wb_we_o(wb_we), .wb_pc_o(wb_pc), .wb_waddr_o(wb_waddr), .wb_wdata_o(wb_wdata)
	);

	mips_checker #(.END_IDX(END_IDX)) commit_check(
		.clk, .rst_n_i(rst_n), .done_i(done),
		.prog_i(imem), .data_init_i(dmem),
		.inst_addr_i(inst_addr), .data_addr_i(data_addr), .data_wdata_i(data_wdata),
		.data_we_i(data_we), .wb_we_i(wb_we), .wb_pc_i(wb_pc),
		.wb_waddr_i(wb_waddr), .wb_wdata_i(wb_wdata), .errors_o(errors)
	);

	// Zero wait state memories
	assign inst_rdata = imem[inst_addr[9:2]];
	assign data_rdata = dmem[data_addr[7:2]];

	always @(posedge clk) begin
		if (data_we) begin
			dmem[data_addr[7:2]] <= data_wdata;
		end
	end

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic RegAddr_t pick_reg();
		logic [31:0] r;
		r = lcg_next();
		return {2'b00, r[26:24]};
	endfunction

	function automatic Inst_t enc_r(RegAddr_t rs, RegAddr_t rt, RegAddr_t rd,
			logic [4:0] sh, Funct_t fn);
		return {OP_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic Inst_t enc_i(Opcode_t op, RegAddr_t rs, RegAddr_t rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic build_program;
		logic [31:0] r;
		RegAddr_t    d, s, t;
		Funct_t      fn;
		Opcode_t     op;
		int          i, k, tgt;
		logic        prev_br;
		for (int n = 0; n < 256; n++) begin
			imem[n] = '0;
		end
		i = 0;
		prev_br = 1'b0;
		while (i < END_IDX) begin
			r = lcg_next();
			d = pick_reg();
			s = pick_reg();
			t = pick_reg();
			k = int'(r[27:24]);
			if (k < 6) begin
				case (r[18:16])
					3'd0: fn = FN_ADDU;
					3'd1: fn = FN_SUBU;
					3'd2: fn = FN_AND;
					3'd3: fn = FN_OR;
					3'd4: fn = FN_XOR;
					3'd5: fn = FN_SLT;
					3'd6: fn = FN_SLL;
					default: fn = FN_SRL;
				endcase
				if (fn == FN_SLL || fn == FN_SRL) imem[i] = enc_r('0, t, d, r[12:8], fn);
				else imem[i] = enc_r(s, t, d, 5'd0, fn);
			end else if (k < 10) begin
				case (r[18:16])
					3'd1: op = OP_SLTI;
					3'd2: op = OP_ANDI;
					3'd3: op = OP_ORI;
					3'd4: op = OP_XORI;
					3'd5: op = OP_LUI;
					default: op = OP_ADDIU;
				endcase
				imem[i] = enc_i(op, s, d, r[15:0]);
			end else if (k < 12) begin
				imem[i] = enc_i(OP_LW, '0, d, {8'b0, r[13:8], 2'b00});
			end else if (k == 12) begin
				imem[i] = enc_i(OP_SW, '0, t, {8'b0, r[13:8], 2'b00});
			end else if (k == 13 && i + 1 < END_IDX) begin
				// Load followed by a reader of its result
				if (d == '0) d = 5'd1;
				imem[i] = enc_i(OP_LW, '0, d, {8'b0, r[13:8], 2'b00});
				i++;
				imem[i] = enc_r(d, t, s, 5'd0, FN_ADDU);
			end else if (!prev_br && i < END_IDX - 2) begin
				tgt = i + 2 + int'(r[12:8]);
				if (tgt > END_IDX - 1) tgt = END_IDX - 1;
				if (r[13]) t = s;
				op = r[14] ? OP_BEQ : OP_BNE;
				imem[i] = enc_i(op, s, t, 16'(tgt - i - 1));
			end else begin
				imem[i] = enc_r(s, t, d, 5'd0, FN_ADDU);
			end
			prev_br = (imem[i][31:26] == OP_BEQ || imem[i][31:26] == OP_BNE);
			i++;
		end
		// Spin on itself with a no-op delay slot
		imem[END_IDX] = enc_i(OP_BEQ, '0, '0, 16'hffff);
		imem[END_IDX + 1] = '0;
		for (int n = 0; n < 64; n++) begin
			dmem[n] <= lcg_next();
		end
	endtask

	initial begin
		rst_n = 1'b0;
		done = 1'b0;
		lcg_state = 32'd23;
		build_program();
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		while (inst_addr != END_IDX * 4) @(posedge clk);
		// Drain the pipeline
		repeat (10) @(posedge clk);
		done <= 1'b1;
		repeat (2) @(posedge clk);
		$display("checks finished with %0d errors", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the program did not finish");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== verilog.f ====
logic/cpu_isa_pkg.sv
logic/cpu_pipe_pkg.sv
logic/regs.sv
logic/cpu_if.sv
logic/cpu_id.sv
logic/cpu_ex.sv
logic/cpu_mem.sv
logic/trivial_mips.sv
verification/cpu_asserts.sv
verification/mips_checker.sv
verification/tb_trivial_mips.sv
